/* ascon_hash_top.f */
+incdir+bench
source/ascon_pkg.sv
source/ascon_padder.sv
source/block_fifo.sv
source/ascon_round.sv
source/ascon_perm.sv
source/hash_ctrl.sv
source/ascon_hash_top.sv
bench/tb_ascon_hash.sv

/* bench/tb_ascon_model.svh */
// Reference model for Ascon-Hash256
// Table S-box round, p12 permutation
// Message padding and sponge digest

`ifndef TB_ASCON_MODEL_SVH
`define TB_ASCON_MODEL_SVH

// Message as a byte queue, byte 0 first
typedef logic [7:0] msg_bytes_t [$];

// Ascon 5-bit S-box, x0 is the MSB of the index
localparam logic [4:0] SBOX_LUT [0:31] = '{
    5'h04, 5'h0b, 5'h1f, 5'h14, 5'h1a, 5'h15, 5'h09, 5'h02,
    5'h1b, 5'h05, 5'h08, 5'h12, 5'h1d, 5'h03, 5'h06, 5'h1c,
    5'h1e, 5'h13, 5'h07, 5'h0e, 5'h00, 5'h0d, 5'h11, 5'h18,
    5'h10, 5'h0c, 5'h01, 5'h19, 5'h16, 5'h0a, 5'h0f, 5'h17
};

// Right rotation via a doubled word
function automatic ascon_word_t rotr(input ascon_word_t w, input int n);
    logic [127:0] dbl;
    dbl = {w, w} >> n;
    return dbl[63:0];
endfunction

// One round with round index r of p12
function automatic ascon_state_t apply_round(input ascon_state_t st, input int r);
    ascon_state_t o;
    logic [4:0]   col;
    logic [7:0]   rc;
    // Constant from the spec formula, high nibble counts down
    rc = 8'(((15 - r) << 4) | r);
    st.s2[7:0] = st.s2[7:0] ^ rc;
    // Substitution column by column
    for (int b = 0; b < 64; b++) begin
        col = {st.s0[b], st.s1[b], st.s2[b], st.s3[b], st.s4[b]};
        {o.s0[b], o.s1[b], o.s2[b], o.s3[b], o.s4[b]} = SBOX_LUT[col];
    end
    // Linear diffusion per word
    o.s0 = o.s0 ^ rotr(o.s0, 19) ^ rotr(o.s0, 28);
    o.s1 = o.s1 ^ rotr(o.s1, 61) ^ rotr(o.s1, 39);
    o.s2 = o.s2 ^ rotr(o.s2, 1) ^ rotr(o.s2, 6);
    o.s3 = o.s3 ^ rotr(o.s3, 10) ^ rotr(o.s3, 17);
    o.s4 = o.s4 ^ rotr(o.s4, 7) ^ rotr(o.s4, 41);
    return o;
endfunction

function automatic ascon_state_t permute_p12(input ascon_state_t st);
    for (int r = 0; r < 12; r++) begin
        st = apply_round(st, r);
    end
    return st;
endfunction

// Digest words packed low word first
function automatic logic [255:0] hash256_digest(input msg_bytes_t msg);
    ascon_state_t st;
    ascon_word_t  blk;
    logic [255:0] dig;
    int           idx;
    int           nblk;
    st    = '0;
    st.s0 = 64'h0000_0801_00cc_0002;
    st    = permute_p12(st);
    // Always one block more than the full blocks, pad byte included
    nblk = msg.size() / 8 + 1;
    for (int k = 0; k < nblk; k++) begin
        for (int j = 0; j < 8; j++) begin
            idx = 8 * k + j;
            if (idx < msg.size()) begin
                blk[8*j +: 8] = msg[idx];
            end else if (idx == msg.size()) begin
                blk[8*j +: 8] = 8'h01;
            end else begin
                blk[8*j +: 8] = 8'h00;
            end
        end
        st.s0 = st.s0 ^ blk;
        st    = permute_p12(st);
    end
    // Squeeze, p12 only between words
    for (int w = 0; w < 4; w++) begin
        if (w > 0) begin
            st = permute_p12(st);
        end
        dig[64*w +: 64] = st.s0;
    end
    return dig;
endfunction

`endif

/* bench/tb_ascon_hash.sv */
// Testbench for the Ascon-Hash256 accelerator
// Stream driver, digest collector, compare tasks
// Directed tests, cycle timeout and summary

`timescale 1ns/1ps
`default_nettype none

module tb_ascon_hash;
    import ascon_pkg::*;

    `include "tb_ascon_model.svh"

    localparam int CLK_PERIOD = 20;
    localparam int QTR        = CLK_PERIOD / 4;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        start_i;
    logic        busy_o;
    logic        done_o;
    ascon_word_t s_axis_tdata_i;
    ascon_keep_t s_axis_tkeep_i;
    logic        s_axis_tlast_i;
    logic        s_axis_tvalid_i;
    logic        s_axis_tready_o;
    ascon_word_t m_axis_tdata_o;
    logic        m_axis_tlast_o;
    logic        m_axis_tvalid_o;
    logic        m_axis_tready_i;

    integer      seed = 32'hd0d0_c142;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          done_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    // Random lengths, drawn up front for the timeout budget
    int          len_stall [2];
    int          len_queue [3];

    ascon_hash_top #(
        .FIFO_DEPTH (4)
    ) i_dut (
        .clk             (clk),
        .rst_i           (rst_i),
        .start_i         (start_i),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tkeep_i  (s_axis_tkeep_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tready_o (s_axis_tready_o),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tready_i (m_axis_tready_i)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (done_o === 1'b1) begin
            done_count++;
        end
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: no finish after %0d clock cycles", cycle_count);
        $display("TESTS FAILED");
        $finish;
    end

    // --------------------
    // Compare tasks
    // --------------------

    task automatic check_word(input ascon_word_t act, input ascon_word_t exp, input string what);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, act, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%0t: %s pass", $time, name);
        end else begin
            $display("%0t: %s had %0d errors", $time, name, error_count - errors_before);
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------

    function automatic msg_bytes_t make_message(input int len);
        msg_bytes_t m;
        for (int i = 0; i < len; i++) begin
            m.push_back(8'($random(seed)));
        end
        return m;
    endfunction

    function automatic int hash_budget(input int len);
        return (len / 8 + 1 + 2) * 14 * 4;
    endfunction

    // Holds one beat until the padder takes it
    task automatic drive_beat(input ascon_word_t data, input ascon_keep_t keep, input logic last);
        @(negedge clk);
        s_axis_tdata_i  = data;
        s_axis_tkeep_i  = keep;
        s_axis_tlast_i  = last;
        s_axis_tvalid_i = 1'b1;
        #(QTR);
        while (!s_axis_tready_o) begin
            @(negedge clk);
            #(QTR);
        end
        @(posedge clk);
    endtask

    task automatic send_message(input msg_bytes_t msg);
        ascon_word_t data;
        ascon_keep_t keep;
        int          nbeats;
        nbeats = (msg.size() == 0) ? 1 : (msg.size() + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            for (int j = 0; j < 8; j++) begin
                keep[j] = (8 * b + j) < msg.size();
                // Junk in unkept lanes must be masked
                data[8*j +: 8] = keep[j] ? msg[8*b + j] : 8'(8'hc3 + 16 * b + j);
            end
            drive_beat(data, keep, b == nbeats - 1);
        end
        @(negedge clk);
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i  = 1'b0;
    endtask

    // Optional second pulse lands while busy
    task automatic start_hash(input logic extra);
        @(negedge clk);
        start_i = 1'b1;
        @(negedge clk);
        start_i = extra;
        #(QTR);
        check_flag(busy_o, 1'b1, "busy_o after start_i");
        @(negedge clk);
        start_i = 1'b0;
    endtask

    // Stray start pulse while the first digest word is on the bus
    task automatic start_while_squeezing();
        @(negedge clk);
        while (m_axis_tvalid_o !== 1'b1) begin
            @(negedge clk);
        end
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic collect_digest(input logic [255:0] exp, input logic stall);
        int k;
        int done_before;
        k           = 0;
        done_before = done_count;
        while (k < DIGEST_WORDS) begin
            @(negedge clk);
            m_axis_tready_i = stall ? 1'($random(seed)) : 1'b1;
            #(QTR);
            if (m_axis_tvalid_o && m_axis_tready_i) begin
                check_word(m_axis_tdata_o, exp[64*k +: 64], $sformatf("digest word %0d", k));
                check_flag(m_axis_tlast_o, k == DIGEST_WORDS - 1, "m_axis_tlast_o");
                k++;
            end
        end
        // Cycle after the closing word
        @(negedge clk);
        m_axis_tready_i = 1'b0;
        #(QTR);
        check_flag(done_o, 1'b1, "done_o after last word");
        check_flag(busy_o, 1'b0, "busy_o after last word");
        check_flag(m_axis_tvalid_o, 1'b0, "m_axis_tvalid_o after last word");
        @(negedge clk);
        #(QTR);
        check_flag(done_o, 1'b0, "done_o one cycle wide");
        check_flag(done_count - done_before == 1, 1'b1, "single done_o pulse");
    endtask

    // Stream and hash side by side
    task automatic run_hash(input msg_bytes_t msg, input logic stall);
        logic [255:0] exp;
        exp = hash256_digest(msg);
        fork
            send_message(msg);
            begin
                start_hash(1'b0);
                collect_digest(exp, stall);
            end
        join
    endtask

    // --------------------
    // Directed tests
    // --------------------

    task automatic reset_and_empty_message();
        int         errs;
        msg_bytes_t m;
        errs = error_count;
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(done_o, 1'b0, "done_o after reset");
        check_flag(m_axis_tvalid_o, 1'b0, "m_axis_tvalid_o after reset");
        check_flag(s_axis_tready_o, 1'b0, "s_axis_tready_o right after reset");
        run_hash(m, 1'b0);
        report_test("reset and empty message", errs);
    endtask

    task automatic partial_final_beats();
        int errs;
        errs = error_count;
        for (int n = 1; n <= 23; n++) begin
            if (n != 8) begin
                run_hash(make_message(n), 1'b0);
            end
        end
        report_test("partial final beat", errs);
    endtask

    task automatic full_final_beats();
        int errs;
        errs = error_count;
        run_hash(make_message(8), 1'b0);
        run_hash(make_message(16), 1'b0);
        run_hash(make_message(32), 1'b0);
        report_test("full final beat", errs);
    endtask

    task automatic output_backpressure();
        int errs;
        errs = error_count;
        for (int i = 0; i < 2; i++) begin
            run_hash(make_message(len_stall[i]), 1'b1);
        end
        report_test("output back-pressure", errs);
    endtask

    task automatic queued_messages();
        int         errs;
        msg_bytes_t m0;
        msg_bytes_t m1;
        msg_bytes_t m2;
        errs = error_count;
        m0   = make_message(len_queue[0]);
        m1   = make_message(len_queue[1]);
        m2   = make_message(len_queue[2]);
        // At most five blocks, so FIFO plus padder hold them all
        send_message(m0);
        send_message(m1);
        send_message(m2);
        check_flag(busy_o, 1'b0, "busy_o with messages queued");
        start_hash(1'b1);
        // A start taken mid-squeeze would corrupt this digest
        fork
            collect_digest(hash256_digest(m0), 1'b0);
            start_while_squeezing();
        join
        start_hash(1'b1);
        collect_digest(hash256_digest(m1), 1'b0);
        start_hash(1'b0);
        collect_digest(hash256_digest(m2), 1'b0);
        repeat (5) @(negedge clk);
        #(QTR);
        check_flag(busy_o, 1'b0, "busy_o idle after queue drained");
        report_test("queued messages", errs);
    endtask

    initial begin
        int limit;
        rst_i           = 1'b1;
        start_i         = 1'b0;
        s_axis_tdata_i  = '0;
        s_axis_tkeep_i  = '0;
        s_axis_tlast_i  = 1'b0;
        s_axis_tvalid_i = 1'b0;
        m_axis_tready_i = 1'b0;

        len_stall[0] = $unsigned($random(seed)) % 40;
        len_stall[1] = $unsigned($random(seed)) % 40;
        len_queue[0] = $unsigned($random(seed)) % 16;
        len_queue[1] = $unsigned($random(seed)) % 8;
        len_queue[2] = $unsigned($random(seed)) % 16;

        // Budget per message plus reset and slack
        limit = 10 + 200 + hash_budget(0);
        for (int n = 1; n <= 23; n++) begin
            limit += (n != 8) ? hash_budget(n) : 0;
        end
        limit += hash_budget(8) + hash_budget(16) + hash_budget(32);
        limit += hash_budget(len_stall[0]) + hash_budget(len_stall[1]);
        for (int i = 0; i < 3; i++) begin
            limit += hash_budget(len_queue[i]);
        end
        cycle_limit = limit;

        repeat (10) @(negedge clk);
        rst_i = 1'b0;
        #(QTR);

        reset_and_empty_message();
        partial_final_beats();
        full_final_beats();
        output_backpressure();
        queued_messages();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/ascon_hash_top.sv */
// Ascon-Hash256 accelerator top level
// Padder, block FIFO, sponge controller and permutation engine

`timescale 1ns/1ps
`default_nettype none

module ascon_hash_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   done_o,
    // Message byte stream
    input  ascon_pkg::ascon_word_t s_axis_tdata_i,
    input  ascon_pkg::ascon_keep_t s_axis_tkeep_i,
    input  logic                   s_axis_tlast_i,
    input  logic                   s_axis_tvalid_i,
    output logic                   s_axis_tready_o,
    // Digest stream
    output ascon_pkg::ascon_word_t m_axis_tdata_o,
    output logic                   m_axis_tlast_o,
    output logic                   m_axis_tvalid_o,
    input  logic                   m_axis_tready_i
);
    import ascon_pkg::*;

    // Padder to FIFO
    ascon_block_t blk;
    logic         blk_valid;
    logic         blk_ready;

    // FIFO to controller
    ascon_block_t fifo_blk;
    logic         fifo_valid;
    logic         fifo_ready;

    // Controller to permutation
    logic         perm_init;
    logic         perm_absorb;
    logic         perm_permute;
    ascon_word_t  absorb_word;
    ascon_word_t  perm_s0;
    logic         perm_ready;

    ascon_padder u_padder (
        .clk             (clk),
        .rst_i           (rst_i),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tkeep_i  (s_axis_tkeep_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tready_o (s_axis_tready_o),
        .blk_o           (blk),
        .blk_valid_o     (blk_valid),
        .blk_ready_i     (blk_ready)
    );

    // Lets later messages queue while one is hashed
    block_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_blk_i   (blk),
        .wr_valid_i (blk_valid),
        .wr_ready_o (blk_ready),
        .rd_blk_o   (fifo_blk),
        .rd_valid_o (fifo_valid),
        .rd_ready_i (fifo_ready)
    );

    hash_ctrl u_ctrl (
        .clk             (clk),
        .rst_i           (rst_i),
        .start_i         (start_i),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .blk_i           (fifo_blk),
        .blk_valid_i     (fifo_valid),
        .blk_ready_o     (fifo_ready),
        .perm_ready_i    (perm_ready),
        .perm_s0_i       (perm_s0),
        .init_o          (perm_init),
        .absorb_o        (perm_absorb),
        .permute_o       (perm_permute),
        .absorb_word_o   (absorb_word),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tready_i (m_axis_tready_i)
    );

    ascon_perm u_perm (
        .clk           (clk),
        .rst_i         (rst_i),
        .init_i        (perm_init),
        .absorb_i      (perm_absorb),
        .permute_i     (perm_permute),
        .absorb_word_i (absorb_word),
        .s0_o          (perm_s0),
        .ready_o       (perm_ready)
    );

endmodule

`default_nettype wire

/* source/hash_ctrl.sv */
// Hash256 sponge controller
// Init, absorb and squeeze sequencing of the permutation
// Digest word output stream, busy and done status

`timescale 1ns/1ps
`default_nettype none

module hash_ctrl (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    start_i,
    output logic                    busy_o,
    output logic                    done_o,
    input  ascon_pkg::ascon_block_t blk_i,
    input  logic                    blk_valid_i,
    output logic                    blk_ready_o,
    input  logic                    perm_ready_i,
    input  ascon_pkg::ascon_word_t  perm_s0_i,
    output logic                    init_o,
    output logic                    absorb_o,
    output logic                    permute_o,
    output ascon_pkg::ascon_word_t  absorb_word_o,
    output ascon_pkg::ascon_word_t  m_axis_tdata_o,
    output logic                    m_axis_tlast_o,
    output logic                    m_axis_tvalid_o,
    input  logic                    m_axis_tready_i
);
    import ascon_pkg::*;

    localparam int CW = $clog2(DIGEST_WORDS);

    hash_state_e   state_q;
    hash_state_e   state_d;
    // Digest words already sent
    logic [CW-1:0] cnt_q;
    // Last flag of the block being absorbed
    logic          last_q;
    logic          done_q;

    logic          last_word;
    logic          word_take;

    // --------------------
    // Output stream
    // --------------------

    // S0 is the digest word, held while the engine is idle
    assign m_axis_tdata_o  = perm_s0_i;
    assign m_axis_tvalid_o = state_q == SQUEEZE_OUT;
    assign last_word       = cnt_q == CW'(DIGEST_WORDS - 1);
    assign m_axis_tlast_o  = last_word;
    assign word_take       = m_axis_tvalid_o && m_axis_tready_i;

    assign busy_o          = state_q != IDLE;
    assign done_o          = done_q;
    assign absorb_word_o   = blk_i.data;

    // Blocks pulled only once the engine has finished
    assign blk_ready_o     = (state_q == WAIT_BLOCK) && perm_ready_i;

    // --------------------
    // Next state and pulses
    // --------------------

    always_comb begin
        state_d   = state_q;
        init_o    = 1'b0;
        absorb_o  = 1'b0;
        permute_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    init_o  = 1'b1;
                    state_d = INIT_PERM;
                end
            end
            INIT_PERM: begin
                if (perm_ready_i) begin
                    state_d = WAIT_BLOCK;
                end
            end
            WAIT_BLOCK: begin
                if (blk_valid_i && blk_ready_o) begin
                    absorb_o = 1'b1;
                    state_d  = ABSORB_PERM;
                end
            end
            ABSORB_PERM: begin
                // Final block leads into the squeeze
                if (perm_ready_i) begin
                    state_d = last_q ? SQUEEZE_OUT : WAIT_BLOCK;
                end
            end
            SQUEEZE_OUT: begin
                if (word_take && last_word) begin
                    state_d = IDLE;
                end else if (word_take) begin
                    permute_o = 1'b1;
                    state_d   = SQUEEZE_PERM;
                end
            end
            SQUEEZE_PERM: begin
                if (perm_ready_i) begin
                    state_d = SQUEEZE_OUT;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            last_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // One pulse after the closing digest word
            done_q  <= word_take && last_word;
            if (init_o) begin
                cnt_q <= '0;
            end else if (permute_o) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (absorb_o) begin
                last_q <= blk_i.last;
            end
        end
    end

endmodule

`default_nettype wire

/* source/ascon_perm.sv */
// Ascon p12 engine, one round per cycle
// 320-bit state register with IV load and rate absorb
// Round counter and ready flag

`timescale 1ns/1ps
`default_nettype none

module ascon_perm (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   init_i,
    input  logic                   absorb_i,
    input  logic                   permute_i,
    input  ascon_pkg::ascon_word_t absorb_word_i,
    output ascon_pkg::ascon_word_t s0_o,
    output logic                   ready_o
);
    import ascon_pkg::*;

    ascon_state_t state_q;
    // Zero means idle, otherwise the next round to run
    logic [3:0]   round_q;

    ascon_state_t round_in;
    ascon_state_t round_out;
    logic         start;

    assign ready_o = round_q == '0;
    assign start   = ready_o && (init_i || absorb_i || permute_i);
    assign s0_o    = state_q.s0;

    // Round input: fresh IV, absorbed block or running state
    always_comb begin
        round_in = state_q;
        if (ready_o && init_i) begin
            round_in    = '0;
            round_in.s0 = HASH_IV;
        end else if (ready_o && absorb_i) begin
            round_in.s0 = state_q.s0 ^ absorb_word_i;
        end
    end

    // First round runs in the same cycle as the load
    ascon_round u_round (
        .state_i (round_in),
        .rc_i    (ROUND_CONST[round_q]),
        .state_o (round_out)
    );

    // State advances on a start and on every busy cycle
    always_ff @(posedge clk) begin
        if (start || !ready_o) begin
            state_q <= round_out;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            round_q <= '0;
        end else if (start) begin
            round_q <= 4'd1;
        end else if (!ready_o) begin
            // Wrap to idle after the twelfth round
            if (round_q == 4'(NUM_ROUNDS - 1)) begin
                round_q <= '0;
            end else begin
                round_q <= round_q + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/ascon_round.sv */
// One Ascon round, purely combinational
// Constant addition, bit-sliced 5-bit S-box, linear diffusion layer

`timescale 1ns/1ps
`default_nettype none

module ascon_round (
    input  ascon_pkg::ascon_state_t state_i,
    input  logic [7:0]              rc_i,
    output ascon_pkg::ascon_state_t state_o
);
    import ascon_pkg::*;

    ascon_word_t x0, x1, x2, x3, x4;
    ascon_word_t t0, t1, t2, t3, t4;
    ascon_word_t y0, y1, y2, y3, y4;

    // Right rotate of one word
    function automatic ascon_word_t ror(input ascon_word_t w, input int n);
        ror = (w >> n) | (w << (64 - n));
    endfunction

    // --------------------
    // Constant addition and S-box
    // --------------------

    always_comb begin
        // Constant goes into the low byte of S2
        x0 = state_i.s0;
        x1 = state_i.s1;
        x2 = state_i.s2 ^ {56'd0, rc_i};
        x3 = state_i.s3;
        x4 = state_i.s4;

        // Input mixing
        x0 = x0 ^ x4;
        x4 = x4 ^ x3;
        x2 = x2 ^ x1;

        // Chi-like core
        t0 = ~x0 & x1;
        t1 = ~x1 & x2;
        t2 = ~x2 & x3;
        t3 = ~x3 & x4;
        t4 = ~x4 & x0;
        x0 = x0 ^ t1;
        x1 = x1 ^ t2;
        x2 = x2 ^ t3;
        x3 = x3 ^ t4;
        x4 = x4 ^ t0;

        // Output mixing
        y1 = x1 ^ x0;
        y0 = x0 ^ x4;
        y3 = x3 ^ x2;
        y2 = ~x2;
        y4 = x4;
    end

    // --------------------
    // Linear layer
    // --------------------

    // Each word has its own rotation pair
    assign state_o.s0 = y0 ^ ror(y0, 19) ^ ror(y0, 28);
    assign state_o.s1 = y1 ^ ror(y1, 61) ^ ror(y1, 39);
    assign state_o.s2 = y2 ^ ror(y2, 1)  ^ ror(y2, 6);
    assign state_o.s3 = y3 ^ ror(y3, 10) ^ ror(y3, 17);
    assign state_o.s4 = y4 ^ ror(y4, 7)  ^ ror(y4, 41);

endmodule

`default_nettype wire

/* source/block_fifo.sv */
// First-word-fall-through FIFO for padded rate blocks
// Circular buffer with read/write pointers and fill count

`timescale 1ns/1ps
`default_nettype none

module block_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  ascon_pkg::ascon_block_t wr_blk_i,
    input  logic                    wr_valid_i,
    output logic                    wr_ready_o,
    output ascon_pkg::ascon_block_t rd_blk_o,
    output logic                    rd_valid_o,
    input  logic                    rd_ready_i
);
    import ascon_pkg::*;

    localparam int AW = $clog2(DEPTH);

    ascon_block_t  mem [0:DEPTH-1];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;

    logic          do_wr;
    logic          do_rd;

    // Flags straight from the fill count
    assign wr_ready_o = count_q != (AW + 1)'(DEPTH);
    assign rd_valid_o = count_q != '0;
    assign do_wr      = wr_valid_i && wr_ready_o;
    assign do_rd      = rd_valid_o && rd_ready_i;

    // Head entry shows without a read request
    assign rd_blk_o   = mem[rd_ptr_q];

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_blk_i;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count_q <= count_q + 1'b1;
            end else if (do_rd && !do_wr) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/ascon_padder.sv */
// Stream padder for Hash256 messages
// Masks unkept lanes and appends the 0x01 pad byte
// Registered block output with valid/ready handshake
// Extra pad block after a full final beat

`timescale 1ns/1ps
`default_nettype none

module ascon_padder (
    input  logic                    clk,
    input  logic                    rst_i,
    input  ascon_pkg::ascon_word_t  s_axis_tdata_i,
    input  ascon_pkg::ascon_keep_t  s_axis_tkeep_i,
    input  logic                    s_axis_tlast_i,
    input  logic                    s_axis_tvalid_i,
    output logic                    s_axis_tready_o,
    output ascon_pkg::ascon_block_t blk_o,
    output logic                    blk_valid_o,
    input  logic                    blk_ready_i
);
    import ascon_pkg::*;

    ascon_block_t blk_q;
    logic         valid_q;
    // Full final beat seen, pad block still owed
    logic         pad_q;
    // Holds off the input for one cycle out of reset
    logic         en_q;

    ascon_keep_t  pad_lane;
    ascon_word_t  beat_data;
    logic         out_free;
    logic         take;
    logic         full_beat;

    // --------------------
    // Handshake
    // --------------------

    // Output register empty or being drained this cycle
    assign out_free        = !valid_q || blk_ready_i;
    assign s_axis_tready_o = en_q && out_free && !pad_q;
    assign take            = s_axis_tvalid_i && s_axis_tready_o;
    assign full_beat       = &s_axis_tkeep_i;

    // --------------------
    // Lane masking and pad byte
    // --------------------

    always_comb begin
        // First unkept lane of a contiguous keep run, none when all kept
        pad_lane = {s_axis_tkeep_i[6:0], 1'b1} ^ s_axis_tkeep_i;
        for (int l = 0; l < 8; l++) begin
            if (s_axis_tkeep_i[l]) begin
                beat_data[8*l +: 8] = s_axis_tdata_i[8*l +: 8];
            end else if (pad_lane[l] && s_axis_tlast_i) begin
                beat_data[8*l +: 8] = 8'h01;
            end else begin
                beat_data[8*l +: 8] = 8'h00;
            end
        end
    end

    // Control flags
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            pad_q   <= 1'b0;
            en_q    <= 1'b0;
        end else begin
            en_q <= 1'b1;
            if (pad_q && out_free) begin
                valid_q <= 1'b1;
                pad_q   <= 1'b0;
            end else if (take) begin
                valid_q <= 1'b1;
                pad_q   <= s_axis_tlast_i && full_beat;
            end else if (blk_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Block payload
    always_ff @(posedge clk) begin
        if (pad_q && out_free) begin
            // Lone pad block, 0x01 in byte 0
            blk_q.data <= 64'h01;
            blk_q.last <= 1'b1;
        end else if (take) begin
            blk_q.data <= beat_data;
            // A full final beat is not the last block
            blk_q.last <= s_axis_tlast_i && !full_beat;
        end
    end

    assign blk_o       = blk_q;
    assign blk_valid_o = valid_q;

endmodule

`default_nettype wire

/* source/ascon_pkg.sv */
// Shared Ascon definitions
// Word, keep, state and rate-block types
// Hash controller state enum
// Hash256 IV, p12 round constants, digest length

`default_nettype none

package ascon_pkg;

    // --------------------
    // Basic types
    // --------------------

    // One Ascon word, byte 0 in bits 7:0
    typedef logic [63:0] ascon_word_t;

    // Byte enables for one stream beat
    typedef logic [7:0] ascon_keep_t;

    // Full 320-bit permutation state
    typedef struct packed {
        ascon_word_t s0;
        ascon_word_t s1;
        ascon_word_t s2;
        ascon_word_t s3;
        ascon_word_t s4;
    } ascon_state_t;

    // One padded rate block plus end-of-message marker
    typedef struct packed {
        ascon_word_t data;
        logic        last;
    } ascon_block_t;

    // Sponge controller states
    typedef enum logic [2:0] {
        IDLE,
        INIT_PERM,
        WAIT_BLOCK,
        ABSORB_PERM,
        SQUEEZE_OUT,
        SQUEEZE_PERM
    } hash_state_e;

    // --------------------
    // Constants
    // --------------------

    localparam int NUM_ROUNDS   = 12;
    localparam int DIGEST_WORDS = 4;

    // Initial S0 for Hash256, remaining words start at zero
    localparam ascon_word_t HASH_IV = 64'h0000_0801_00cc_0002;

    // Constants for p12, first round first
    localparam logic [7:0] ROUND_CONST [0:NUM_ROUNDS-1] = '{
        8'hf0, 8'he1, 8'hd2, 8'hc3, 8'hb4, 8'ha5,
        8'h96, 8'h87, 8'h78, 8'h69, 8'h5a, 8'h4b
    };

endpackage

`default_nettype wire
